//--- hdl/cpu_macros.svh
// CPU width, register count, instruction field and reset PC definitions
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_XLEN      32
`define CPU_REG_BITS  5
`define CPU_REG_COUNT 32
`define CPU_RESET_PC  32'h0000_0000

// Instruction fields
`define CPU_OP_HI  31
`define CPU_OP_LO  26
`define CPU_RD_HI  25
`define CPU_RD_LO  21
`define CPU_RS_HI  20
`define CPU_RS_LO  16
`define CPU_RT_HI  15
`define CPU_RT_LO  11
`define CPU_IMM_HI 15
`define CPU_IMM_LO 0
`define CPU_FN_HI  3
`define CPU_FN_LO  0

`endif

//--- hdl/cpu_pkg.sv
// CPU package with word, register, instruction, opcode and ALU types
`default_nettype none

`include "cpu_macros.svh"

package cpuPkg;

	typedef logic [`CPU_XLEN-1:0] wordT;
	typedef logic [`CPU_REG_BITS-1:0] regAddrT;
	typedef logic [`CPU_XLEN-1:0] instrT;

	// All-zero word decodes as a nop
	typedef enum logic [5:0] {
		opNop   = 6'd0,
		opAlu   = 6'd1,
		opAddi  = 6'd2,
		opLoad  = 6'd3,
		opStore = 6'd4,
		opBeq   = 6'd5,
		opHalt  = 6'd63
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluAnd = 4'd2,
		aluOr  = 4'd3,
		aluXor = 4'd4,
		aluSlt = 4'd5
	} aluOpT;

endpackage

`default_nettype wire

//--- hdl/retireIf.sv
// Retire interface carrying the writeback result and halt from MEM/WB
`timescale 1ns/1ps
`default_nettype none

interface retireIf;
	import cpuPkg::*;

	logic writeEn;
	regAddrT writeAddr;
	wordT writeData;
	logic halt;

	modport source (output writeEn, output writeAddr, output writeData, output halt);

	modport regFile (input writeEn, input writeAddr, input writeData);

	modport forward (input writeEn, input writeAddr, input writeData);

endinterface

`default_nettype wire

//--- hdl/fetchUnit.sv
// Fetch stage with program counter, IF/ID register and sticky halt
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module fetchUnit (
	input wire clk,
	input wire rst_n,
	output cpuPkg::wordT instrAddr,
	input wire cpuPkg::instrT instrData,
	input wire redirect,
	input wire cpuPkg::wordT redirectPc,
	input wire stall,
	input wire retired,
	output cpuPkg::instrT idInstr,
	output cpuPkg::wordT idPc,
	output logic halted
);
	import cpuPkg::*;

	wordT pc;
	logic holdPc;

	assign instrAddr = pc;

	// PC parks on a fetched halt until it is flushed or retires
	assign holdPc = halted || (instrData[`CPU_OP_HI:`CPU_OP_LO] == opHalt);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `CPU_RESET_PC;
			idInstr <= '0;
		end else if (!stall) begin
			if (redirect) begin
				pc <= redirectPc;
				idInstr <= '0;
			end else begin
				if (!holdPc)
					pc <= pc + wordT'(4);
				idInstr <= instrData;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall)
			idPc <= pc;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			halted <= 1'b0;
		else if (retired)
			halted <= 1'b1;
	end

endmodule

`default_nettype wire

//--- hdl/decodeUnit.sv
// Decode stage with register file, load-use interlock and ID/EX register
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module decodeUnit (
	input wire clk,
	input wire rst_n,
	input wire cpuPkg::instrT idInstr,
	input wire cpuPkg::wordT idPc,
	retireIf.regFile retire,
	input wire busStall,
	input wire flush,
	output logic loadUseStall,
	output logic exValid,
	output cpuPkg::opcodeT exOp,
	output cpuPkg::aluOpT exAluOp,
	output cpuPkg::regAddrT exRd,
	output cpuPkg::regAddrT exRs,
	output cpuPkg::regAddrT exRt,
	output cpuPkg::wordT exA,
	output cpuPkg::wordT exB,
	output cpuPkg::wordT exImm,
	output cpuPkg::wordT exPc
);
	import cpuPkg::*;

	wordT regs [`CPU_REG_COUNT];
	opcodeT op;
	aluOpT aluSel;
	regAddrT rdF;
	regAddrT rsF;
	regAddrT rtF;
	regAddrT srcB;
	logic usesA;
	logic usesB;
	logic bubble;
	wordT regA;
	wordT regB;
	wordT immExt;

	function automatic wordT readReg(regAddrT addr);
		if (addr == '0)
			return '0;
		else if (retire.writeEn && retire.writeAddr == addr)
			return retire.writeData;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (retire.writeEn)
			regs[retire.writeAddr] <= retire.writeData;
	end

	assign op = opcodeT'(idInstr[`CPU_OP_HI:`CPU_OP_LO]);
	assign rdF = idInstr[`CPU_RD_HI:`CPU_RD_LO];
	assign rsF = idInstr[`CPU_RS_HI:`CPU_RS_LO];
	assign rtF = idInstr[`CPU_RT_HI:`CPU_RT_LO];
	assign immExt = {{(`CPU_XLEN-16){idInstr[`CPU_IMM_HI]}}, idInstr[`CPU_IMM_HI:`CPU_IMM_LO]};

	// Stores and beq take their second operand from rd
	always_comb begin
		usesA = 1'b0;
		usesB = 1'b0;
		srcB = rtF;
		aluSel = aluAdd;
		case (op)
			opAlu: begin
				usesA = 1'b1;
				usesB = 1'b1;
				aluSel = aluOpT'(idInstr[`CPU_FN_HI:`CPU_FN_LO]);
			end
			opAddi, opLoad: usesA = 1'b1;
			opStore, opBeq: begin
				usesA = 1'b1;
				usesB = 1'b1;
				srcB = rdF;
			end
			default: ;
		endcase
		regA = readReg(rsF);
		regB = readReg(srcB);
	end

	assign loadUseStall = exValid && (exOp == opLoad) && (exRd != '0) &&
		((usesA && rsF == exRd) || (usesB && srcB == exRd));
	assign bubble = flush || loadUseStall;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exValid <= 1'b0;
			exOp <= opNop;
		end else if (!busStall) begin
			exValid <= !bubble;
			exOp <= bubble ? opNop : op;
		end
	end

	always_ff @(posedge clk) begin
		if (!busStall) begin
			exAluOp <= aluSel;
			exRd <= rdF;
			exRs <= rsF;
			exRt <= srcB;
			exA <= regA;
			exB <= regB;
			exImm <= immExt;
			exPc <= idPc;
		end
	end

endmodule

`default_nettype wire

//--- hdl/executeUnit.sv
// Execute stage with operand forwarding, ALU, beq resolution and EX/MEM register
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module executeUnit (
	input wire clk,
	input wire rst_n,
	input wire exValid,
	input wire cpuPkg::opcodeT exOp,
	input wire cpuPkg::aluOpT exAluOp,
	input wire cpuPkg::regAddrT exRd,
	input wire cpuPkg::regAddrT exRs,
	input wire cpuPkg::regAddrT exRt,
	input wire cpuPkg::wordT exA,
	input wire cpuPkg::wordT exB,
	input wire cpuPkg::wordT exImm,
	input wire cpuPkg::wordT exPc,
	retireIf.forward retire,
	input wire busStall,
	output logic redirect,
	output cpuPkg::wordT redirectPc,
	output logic flush,
	output cpuPkg::opcodeT memOp,
	output cpuPkg::regAddrT memRd,
	output cpuPkg::wordT memResult,
	output cpuPkg::wordT memStoreData
);
	import cpuPkg::*;

	logic memFwd;
	logic useImm;
	logic taken;
	wordT opA;
	wordT opB;
	wordT aluB;
	wordT result;

	// Newest producer wins, loads in EX/MEM are covered by the interlock
	function automatic wordT fwdSel(regAddrT src, wordT regVal);
		if (memFwd && memRd == src)
			return memResult;
		else if (retire.writeEn && retire.writeAddr == src)
			return retire.writeData;
		else
			return regVal;
	endfunction

	assign memFwd = (memOp == opAlu || memOp == opAddi) && (memRd != '0);
	assign useImm = (exOp == opAddi) || (exOp == opLoad) || (exOp == opStore);

	always_comb begin
		opA = fwdSel(exRs, exA);
		opB = fwdSel(exRt, exB);
		aluB = useImm ? exImm : opB;
		case (exAluOp)
			aluSub: result = opA - aluB;
			aluAnd: result = opA & aluB;
			aluOr: result = opA | aluB;
			aluXor: result = opA ^ aluB;
			aluSlt: result = {{(`CPU_XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
			default: result = opA + aluB;
		endcase
	end

	assign taken = exValid && (exOp == opBeq) && (opA == opB);
	assign redirect = taken;
	assign flush = taken;
	assign redirectPc = exPc + wordT'(4) + {exImm[`CPU_XLEN-3:0], 2'b00};

	always_ff @(posedge clk) begin
		if (!rst_n)
			memOp <= opNop;
		else if (!busStall)
			memOp <= exValid ? exOp : opNop;
	end

	always_ff @(posedge clk) begin
		if (!busStall) begin
			memRd <= exRd;
			memResult <= result;
			memStoreData <= opB;
		end
	end

endmodule

`default_nettype wire

//--- hdl/memoryUnit.sv
// Memory stage with Wishbone classic data master and MEM/WB register
`timescale 1ns/1ps
`default_nettype none

module memoryUnit (
	input wire clk,
	input wire rst_n,
	input wire cpuPkg::opcodeT memOp,
	input wire cpuPkg::regAddrT memRd,
	input wire cpuPkg::wordT memResult,
	input wire cpuPkg::wordT memStoreData,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output cpuPkg::wordT wbAdr,
	output cpuPkg::wordT wbDatO,
	input wire cpuPkg::wordT wbDatI,
	input wire wbAck,
	output logic busStall,
	retireIf.source retire
);
	import cpuPkg::*;

	typedef enum logic {idle, waitAck} busStateT;

	busStateT state;
	logic isLoad;
	logic access;
	logic retireEn;
	logic retireHalt;
	regAddrT retireAddr;
	wordT retireData;

	assign isLoad = (memOp == opLoad);
	assign access = isLoad || (memOp == opStore);

	// Idle cycle with a pending access counts as stalled too
	assign busStall = (state == idle) ? access : !wbAck;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			wbWe <= 1'b0;
		end else begin
			case (state)
				idle: if (access) begin
					state <= waitAck;
					wbCyc <= 1'b1;
					wbStb <= 1'b1;
					wbWe <= (memOp == opStore);
				end
				waitAck: if (wbAck) begin
					state <= idle;
					wbCyc <= 1'b0;
					wbStb <= 1'b0;
					wbWe <= 1'b0;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idle && access) begin
			wbAdr <= memResult;
			wbDatO <= memStoreData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			retireEn <= 1'b0;
			retireHalt <= 1'b0;
		end else if (!busStall) begin
			retireEn <= (memOp == opAlu || memOp == opAddi || isLoad) && (memRd != '0);
			retireHalt <= (memOp == opHalt);
		end
	end

	// Load data is taken on the ack cycle, the only unstalled one for a load
	always_ff @(posedge clk) begin
		if (!busStall) begin
			retireAddr <= memRd;
			retireData <= isLoad ? wbDatI : memResult;
		end
	end

	assign retire.writeEn = retireEn;
	assign retire.writeAddr = retireAddr;
	assign retire.writeData = retireData;
	assign retire.halt = retireHalt;

endmodule

`default_nettype wire

//--- hdl/cpuCore.sv
// Five-stage pipelined CPU core with instruction port and Wishbone data port
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
	input wire clk,
	input wire rst_n,
	output cpuPkg::wordT instrAddr,
	input wire cpuPkg::instrT instrData,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output cpuPkg::wordT wbAdr,
	output cpuPkg::wordT wbDatO,
	input wire cpuPkg::wordT wbDatI,
	input wire wbAck,
	output logic halted
);
	import cpuPkg::*;

	instrT idInstr;
	wordT idPc;
	logic redirect;
	logic flush;
	logic loadUseStall;
	logic busStall;
	logic fetchStall;
	wordT redirectPc;
	logic exValid;
	opcodeT exOp;
	aluOpT exAluOp;
	regAddrT exRd;
	regAddrT exRs;
	regAddrT exRt;
	wordT exA;
	wordT exB;
	wordT exImm;
	wordT exPc;
	opcodeT memOp;
	regAddrT memRd;
	wordT memResult;
	wordT memStoreData;

	retireIf retire();

	assign fetchStall = loadUseStall || busStall;

	fetchUnit i_fetchUnit (
		.clk(clk), .rst_n(rst_n),
		.instrAddr(instrAddr), .instrData(instrData),
		.redirect(redirect), .redirectPc(redirectPc),
		.stall(fetchStall), .retired(retire.halt),
		.idInstr(idInstr), .idPc(idPc), .halted(halted)
	);

	decodeUnit i_decodeUnit (
		.clk(clk), .rst_n(rst_n),
		.idInstr(idInstr), .idPc(idPc), .retire(retire),
		.busStall(busStall), .flush(flush), .loadUseStall(loadUseStall),
		.exValid(exValid), .exOp(exOp), .exAluOp(exAluOp),
		.exRd(exRd), .exRs(exRs), .exRt(exRt),
		.exA(exA), .exB(exB), .exImm(exImm), .exPc(exPc)
	);

	executeUnit i_executeUnit (
		.clk(clk), .rst_n(rst_n),
		.exValid(exValid), .exOp(exOp), .exAluOp(exAluOp),
		.exRd(exRd), .exRs(exRs), .exRt(exRt),
		.exA(exA), .exB(exB), .exImm(exImm), .exPc(exPc),
		.retire(retire), .busStall(busStall),
		.redirect(redirect), .redirectPc(redirectPc), .flush(flush),
		.memOp(memOp), .memRd(memRd), .memResult(memResult), .memStoreData(memStoreData)
	);

	memoryUnit i_memoryUnit (
		.clk(clk), .rst_n(rst_n),
		.memOp(memOp), .memRd(memRd), .memResult(memResult), .memStoreData(memStoreData),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
		.wbDatI(wbDatI), .wbAck(wbAck),
		.busStall(busStall), .retire(retire)
	);

endmodule

`default_nettype wire

//--- testbench/clockGen.sv
// Clock and reset source for the CPU testbench
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rst_n
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/cpu_properties.sv
// Bound checks on the cpuCore Wishbone data port and halt output
`timescale 1ns/1ps
`default_nettype none

module cpuProperties (
	input wire clk,
	input wire rst_n,
	input wire wbCyc,
	input wire wbStb,
	input wire wbWe,
	input wire cpuPkg::wordT wbAdr,
	input wire cpuPkg::wordT wbDatO,
	input wire wbAck,
	input wire halted
);

	resetQuiet: assert property (@(posedge clk) !rst_n |=> !wbCyc && !wbStb && !wbWe && !halted)
		else $error("Bus or halted active after reset");

	stbInsideCyc: assert property (@(posedge clk) disable iff (!rst_n) wbStb |-> wbCyc)
		else $error("wbStb high without wbCyc");

	// Request held until acknowledged
	holdUntilAck: assert property (@(posedge clk) disable iff (!rst_n)
		wbCyc && !wbAck |=> wbStb && $stable(wbAdr) && $stable(wbDatO) && $stable(wbWe))
		else $error("Wishbone request changed before wbAck");

	dropAfterAck: assert property (@(posedge clk) disable iff (!rst_n) wbCyc && wbAck |=> !wbCyc)
		else $error("wbCyc still high after wbAck");

	haltedSticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
		else $error("halted dropped before reset");

	quietAfterHalt: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !$rose(wbCyc))
		else $error("Wishbone cycle started after halt");

endmodule

bind cpuCore cpuProperties i_cpuProperties (
	.clk(clk),
	.rst_n(rst_n),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbWe(wbWe),
	.wbAdr(wbAdr),
	.wbDatO(wbDatO),
	.wbAck(wbAck),
	.halted(halted)
);

`default_nettype wire

//--- testbench/cpuTb.sv
// Testbench running a fixed program on cpuCore against an ISA golden model
`timescale 1ns/1ps
`default_nettype none

`include "cpu_macros.svh"

module cpuTb;
	import cpuPkg::*;

	localparam int HALT_TIMEOUT = 3000;
	localparam int RESET_TIMEOUT = 100;

	logic clk;
	logic rst_n;
	wordT instrAddr;
	instrT instrData;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	wordT wbAdr;
	wordT wbDatO;
	wordT wbDatI;
	logic wbAck;
	logic halted;

	instrT rom [32];
	wordT goldMem [wordT];
	wordT slaveMem [wordT];
	wordT expAddr [$];
	wordT expData [$];
	int storeCount;

	clockGen i_clockGen (.clk(clk), .rst_n(rst_n));

	cpuCore i_cpuCore (
		.clk(clk), .rst_n(rst_n),
		.instrAddr(instrAddr), .instrData(instrData),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbDatO(wbDatO),
		.wbDatI(wbDatI), .wbAck(wbAck), .halted(halted)
	);

	// Combinational instruction port
	assign instrData = rom[instrAddr[6:2]];

	function automatic instrT enc(opcodeT op, regAddrT rd, regAddrT rs, logic [15:0] imm);
		return {op, rd, rs, imm};
	endfunction

	function automatic instrT alu(aluOpT fn, regAddrT rd, regAddrT rs, regAddrT rt);
		return {opAlu, rd, rs, rt, 7'd0, fn};
	endfunction

	function automatic wordT fillWord(wordT addr);
		return {addr[15:0] ^ addr[31:16], ~addr[15:0]} ^ 32'h3c5a0f96;
	endfunction

	function automatic wordT aluModel(aluOpT fn, wordT a, wordT b);
		case (fn)
			aluSub: return a - b;
			aluAnd: return a & b;
			aluOr: return a | b;
			aluXor: return a ^ b;
			aluSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: return a + b;
		endcase
	endfunction

	task automatic abortRun(string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic loadProgram();
		rom = '{default: '0};
		rom[0] = enc(opAddi, 5'd9, 5'd0, 16'd64);
		rom[1] = enc(opAddi, 5'd1, 5'd0, 16'd5);
		rom[2] = enc(opAddi, 5'd2, 5'd0, 16'hfffd);
		rom[3] = alu(aluAdd, 5'd3, 5'd1, 5'd2);
		rom[4] = enc(opStore, 5'd3, 5'd9, 16'd0);
		rom[5] = alu(aluSub, 5'd4, 5'd3, 5'd1);
		rom[6] = alu(aluXor, 5'd5, 5'd4, 5'd3);
		rom[7] = enc(opStore, 5'd4, 5'd9, 16'd4);
		rom[8] = alu(aluAnd, 5'd6, 5'd5, 5'd1);
		rom[9] = alu(aluOr, 5'd7, 5'd6, 5'd2);
		rom[10] = enc(opStore, 5'd7, 5'd9, 16'd8);
		rom[11] = alu(aluSlt, 5'd8, 5'd2, 5'd1);
		rom[12] = enc(opStore, 5'd8, 5'd9, 16'd12);
		rom[13] = enc(opStore, 5'd5, 5'd9, 16'd16);
		// Load-use pairs
		rom[14] = enc(opLoad, 5'd10, 5'd9, 16'd4);
		rom[15] = alu(aluAdd, 5'd11, 5'd10, 5'd1);
		rom[16] = enc(opStore, 5'd11, 5'd9, 16'd20);
		rom[17] = enc(opLoad, 5'd12, 5'd9, 16'd256);
		rom[18] = enc(opAddi, 5'd13, 5'd12, 16'd7);
		rom[19] = enc(opStore, 5'd13, 5'd9, 16'd24);
		// Taken beq skips two and the second beq falls through
		rom[20] = enc(opBeq, 5'd1, 5'd1, 16'd2);
		rom[21] = enc(opAddi, 5'd14, 5'd0, 16'd99);
		rom[22] = enc(opStore, 5'd14, 5'd9, 16'd28);
		rom[23] = enc(opBeq, 5'd1, 5'd2, 16'd3);
		rom[24] = enc(opAddi, 5'd14, 5'd14, 16'd11);
		rom[25] = enc(opStore, 5'd14, 5'd9, 16'd32);
		rom[26] = enc(opLoad, 5'd15, 5'd9, 16'd0);
		rom[27] = enc(opStore, 5'd15, 5'd9, 16'd36);
		rom[28] = enc(opHalt, 5'd0, 5'd0, 16'd0);
		// Never reached once fetch stops at the halt
		rom[29] = enc(opStore, 5'd1, 5'd9, 16'd40);
	endtask

	// Sequential ISA model producing the expected store list
	task automatic buildExpected();
		wordT regs [32];
		wordT pc;
		wordT imm;
		wordT addr;
		instrT w;
		regAddrT rd;
		regAddrT rs;
		regAddrT rt;
		int steps;
		logic running;
		regs = '{default: '0};
		pc = `CPU_RESET_PC;
		running = 1'b1;
		steps = 0;
		while (running && steps < 200) begin
			w = rom[pc[6:2]];
			rd = w[`CPU_RD_HI:`CPU_RD_LO];
			rs = w[`CPU_RS_HI:`CPU_RS_LO];
			rt = w[`CPU_RT_HI:`CPU_RT_LO];
			imm = {{16{w[`CPU_IMM_HI]}}, w[`CPU_IMM_HI:`CPU_IMM_LO]};
			addr = regs[rs] + imm;
			pc = pc + 32'd4;
			steps++;
			case (w[`CPU_OP_HI:`CPU_OP_LO])
				opAlu: regs[rd] = aluModel(aluOpT'(w[`CPU_FN_HI:`CPU_FN_LO]), regs[rs], regs[rt]);
				opAddi: regs[rd] = addr;
				opLoad: regs[rd] = goldMem.exists(addr) ? goldMem[addr] : fillWord(addr);
				opStore: begin
					goldMem[addr] = regs[rd];
					expAddr.push_back(addr);
					expData.push_back(regs[rd]);
				end
				opBeq: if (regs[rd] == regs[rs]) pc = pc + (imm << 2);
				opHalt: running = 1'b0;
				default: ;
			endcase
			regs[0] = '0;
		end
	endtask

	task automatic checkStore();
		assert (storeCount < expAddr.size())
			else abortRun($sformatf("Unexpected extra store to %h at time %0t", wbAdr, $time));
		assert (wbAdr == expAddr[storeCount] && wbDatO == expData[storeCount])
			else abortRun($sformatf("Mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, storeCount, wbDatO, wbAdr, expData[storeCount], expAddr[storeCount]));
		slaveMem[wbAdr] = wbDatO;
		storeCount++;
	endtask

	task automatic ackAccess();
		wbAck <= 1'b1;
		if (wbWe)
			checkStore();
		else
			wbDatI <= slaveMem.exists(wbAdr) ? slaveMem[wbAdr] : fillWord(wbAdr);
	endtask

	// Wishbone slave with 0 to 3 wait cycles before each ack
	initial begin : wishboneSlave
		int seed;
		int waitLeft;
		logic inCycle;
		seed = 32'h813400f8;
		waitLeft = 0;
		inCycle = 1'b0;
		storeCount = 0;
		wbAck = 1'b0;
		wbDatI = '0;
		forever begin
			@(posedge clk);
			if (!rst_n || wbAck) begin
				wbAck <= 1'b0;
				inCycle = 1'b0;
			end else if (wbCyc && wbStb) begin
				if (!inCycle) begin
					inCycle = 1'b1;
					waitLeft = $random(seed) & 3;
				end
				if (waitLeft == 0)
					ackAccess();
				else
					waitLeft = waitLeft - 1;
			end
		end
	end

	initial begin : mainFlow
		int cycles;
		loadProgram();
		buildExpected();
		cycles = 0;
		while (rst_n !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > RESET_TIMEOUT)
				abortRun("Reset was never released");
		end
		cycles = 0;
		while (halted !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > HALT_TIMEOUT)
				abortRun("Timed out waiting for halted");
		end
		// Give the halt checks time to observe the stopped core
		repeat (8) @(negedge clk);
		if (storeCount == expAddr.size()) begin
			$display("Test passed");
			$finish;
		end else begin
			abortRun($sformatf("Saw %0d stores but the program makes %0d", storeCount,
				expAddr.size()));
		end
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/retireIf.sv
hdl/fetchUnit.sv
hdl/decodeUnit.sv
hdl/executeUnit.sv
hdl/memoryUnit.sv
hdl/cpuCore.sv
testbench/clockGen.sv
testbench/cpu_properties.sv
testbench/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
BUILD_DIR ?= obj_dir
FLIST ?= flist.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard hdl/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
